//--- logic/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// data bits carried in one frame
`define UART_DATA_WIDTH 8

// clk cycles per bit on the line, keep it even so the half-bit point is exact
`define UART_CLKS_PER_BIT 8

// parity sense: 0 even, 1 odd
`define UART_PARITY_ODD 0

// transmit buffer entries, power of two
`define TX_FIFO_DEPTH 4

`endif

//--- logic/uart_pkg.sv
`include "uart_cfg.svh"

package uart_pkg;

	// start + data + parity + stop
	localparam int FRAME_BITS = `UART_DATA_WIDTH + 3;

	typedef logic [`UART_DATA_WIDTH-1:0] uart_data_t; // one host byte

	// field view, start bit sits in the lsb so it leaves first
	typedef struct packed {
		logic       stop;   // always 1 on a good frame
		logic       parity; // even or odd per cfg
		uart_data_t data;   // sent lsb first
		logic       start;  // always 0
	} uart_frame_fields_t;

	// same frame word, seen as fields or as a flat shift vector
	typedef union packed {
		uart_frame_fields_t   f;   // build / extract
		logic [FRAME_BITS-1:0] raw; // shift out / shift in
	} uart_frame_t;

endpackage

//--- logic/tx_fifo.sv
`include "uart_cfg.svh"

module tx_fifo (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_write, // one-cycle strobe from host
	input  uart_pkg::uart_data_t i_data,  // qualified by i_write
	input  logic                 i_pop,   // takes o_head this cycle
	output uart_pkg::uart_data_t o_head,  // oldest word
	output logic                 o_empty,
	output logic                 o_full
);
	import uart_pkg::*;

	localparam int PTR_W = $clog2(`TX_FIFO_DEPTH);

	uart_data_t       mem [`TX_FIFO_DEPTH]; // circular storage
	logic [PTR_W-1:0] rd_ptr;               // head slot
	logic [PTR_W-1:0] wr_ptr;               // next free slot
	logic [PTR_W:0]   count;                // occupancy with one extra bit for full
	logic             do_write;
	logic             do_pop;

	assign o_empty = (count == '0);
	assign o_full  = (count == (PTR_W+1)'(`TX_FIFO_DEPTH));

	assign do_write = i_write && !o_full; // writes into a full fifo are lost
	assign do_pop   = i_pop && !o_empty;  // guard against a stray pop

	assign o_head = mem[rd_ptr]; // visible the cycle after the write

	// payload lands in the slot at the write pointer
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps since the depth is a power of two
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_pop})
				2'b10: begin
					count <= count + 1'b1; // write only
				end
				2'b01: begin
					count <= count - 1'b1; // pop only
				end
				default: begin
					count <= count; // idle or write and pop together
				end
			endcase
		end
	end

endmodule

//--- logic/uart_tx.sv
`include "uart_cfg.svh"

module uart_tx (
	input  logic                 clk,
	input  logic                 reset,
	input  uart_pkg::uart_data_t i_head,  // fifo head word
	input  logic                 i_empty, // fifo has nothing queued
	output logic                 o_pop,   // one-cycle pulse, consumes i_head
	output logic                 o_serial, // line, idles high
	output logic                 o_busy
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam int IDX_W = $clog2(FRAME_BITS);

	logic [CNT_W-1:0] baud_cnt;  // free-running bit-period counter
	logic             tick;      // one cycle per bit period
	logic             active_q;  // frame on the line
	logic [IDX_W-1:0] bit_idx;   // bit currently driven, 0 = start
	logic             last_bit;  // stop bit is on the line
	logic             load;      // take a new word at this tick
	uart_frame_t      frame_q;   // shifter, raw[0] drives the line
	uart_frame_t      new_frame; // frame built from the head word

	assign tick = (baud_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (reset || tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// fields of the outgoing frame
	always_comb begin
		new_frame.f.start  = 1'b0;
		new_frame.f.data   = i_head;
		new_frame.f.parity = (^i_head) ^ 1'(`UART_PARITY_ODD); // odd flips the sense
		new_frame.f.stop   = 1'b1;
	end

	assign last_bit = (bit_idx == IDX_W'(FRAME_BITS - 1));

	// start when idle, or chain straight on after the stop bit
	assign load  = tick && !i_empty && (!active_q || last_bit);
	assign o_pop = load;

	always_ff @(posedge clk) begin
		if (reset) begin
			active_q <= 1'b0;
			bit_idx  <= '0;
		end else if (load) begin
			active_q <= 1'b1;
			bit_idx  <= '0; // start bit goes out now
		end else if (tick && active_q) begin
			if (last_bit) begin
				active_q <= 1'b0; // stop bit done, nothing queued
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			frame_q <= new_frame;
		end else if (tick && active_q) begin
			frame_q.raw <= {1'b1, frame_q.raw[FRAME_BITS-1:1]}; // lsb first
		end
	end

	assign o_serial = active_q ? frame_q.raw[0] : 1'b1;

	// queued word or frame in flight
	assign o_busy = !i_empty || active_q;

endmodule

//--- logic/uart_rx.sv
`include "uart_cfg.svh"

module uart_rx (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_serial,     // async line input
	output uart_pkg::uart_data_t o_data,       // valid with o_data_valid
	output logic                 o_data_valid, // one-cycle pulse at mid stop bit
	output logic                 o_rx_error    // parity or stop bit bad
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam int IDX_W = $clog2(`UART_DATA_WIDTH + 1);
	localparam int HALF  = `UART_CLKS_PER_BIT / 2;

	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_START  = 3'd1;
	localparam logic [2:0] ST_DATA   = 3'd2;
	localparam logic [2:0] ST_PARITY = 3'd3;
	localparam logic [2:0] ST_STOP   = 3'd4;

	logic [2:0]       sync_q;       // three-flop synchronizer
	logic             rx_line;      // synchronized line
	logic             line_q;       // previous line value
	logic             fall;         // high to low on the line
	logic [2:0]       state_q;
	logic [CNT_W-1:0] baud_cnt;     // restarted by the falling edge
	logic             mid_start;    // half a bit into the start bit
	logic             bit_end;      // one bit period since last sample
	logic [IDX_W-1:0] data_idx;     // data bits taken so far
	logic             sample_en;    // shift rx_line into the frame
	logic             stop_done;    // stop bit sampled
	uart_frame_t      frame_q;      // samples so far
	uart_frame_t      sample_frame; // frame including this sample
	logic             parity_exp;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q <= '1; // idle line is high
			line_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[1:0], i_serial};
			line_q <= rx_line;
		end
	end

	assign rx_line = sync_q[2];
	assign fall    = line_q && !rx_line;

	assign mid_start = (baud_cnt == CNT_W'(HALF - 1));
	assign bit_end   = (baud_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

	assign stop_done = (state_q == ST_STOP) && bit_end;
	assign sample_en = ((state_q == ST_START) && mid_start && !rx_line)
		|| (((state_q == ST_DATA) || (state_q == ST_PARITY) || (state_q == ST_STOP)) && bit_end);

	// new sample enters at the msb, start bit ends up in raw[0]
	always_comb begin
		sample_frame.raw = {rx_line, frame_q.raw[FRAME_BITS-1:1]};
	end

	assign parity_exp = (^sample_frame.f.data) ^ 1'(`UART_PARITY_ODD);

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q      <= ST_IDLE;
			baud_cnt     <= '0;
			data_idx     <= '0;
			o_data_valid <= 1'b0;
			o_rx_error   <= 1'b0;
		end else begin
			o_data_valid <= 1'b0;
			baud_cnt     <= baud_cnt + 1'b1;
			case (state_q)
				ST_IDLE: begin
					baud_cnt <= '0; // hold until an edge
					if (fall) begin
						state_q <= ST_START;
					end
				end
				ST_START: begin
					if (mid_start) begin
						baud_cnt <= '0;
						data_idx <= '0;
						state_q  <= rx_line ? ST_IDLE : ST_DATA; // glitch rejected
					end
				end
				ST_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (data_idx == IDX_W'(`UART_DATA_WIDTH - 1)) begin
							state_q <= ST_PARITY;
						end else begin
							data_idx <= data_idx + 1'b1;
						end
					end
				end
				ST_PARITY: begin
					if (bit_end) begin
						baud_cnt <= '0;
						state_q  <= ST_STOP;
					end
				end
				ST_STOP: begin
					if (bit_end) begin
						o_data_valid <= 1'b1;
						o_rx_error   <= (sample_frame.f.parity != parity_exp)
							|| !sample_frame.f.stop;
						state_q      <= ST_IDLE; // next edge can come half a bit later
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample_en) begin
			frame_q <= sample_frame;
		end
		if (stop_done) begin
			o_data <= sample_frame.f.data;
		end
	end

endmodule

//--- logic/uart_loop.sv
`include "uart_cfg.svh"

module uart_loop (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_write,      // host write strobe
	input  uart_pkg::uart_data_t i_data,
	input  logic                 i_serial,     // line into the receiver
	output logic                 o_full,       // host must hold off writes
	output logic                 o_busy,       // queued or sending
	output logic                 o_serial,     // line out of the transmitter
	output uart_pkg::uart_data_t o_data,
	output logic                 o_data_valid,
	output logic                 o_rx_error
);
	import uart_pkg::*;

	uart_data_t fifo_head; // word the transmitter takes next
	logic       fifo_empty;
	logic       tx_pop;

	tx_fifo tx_fifo_i (
		.clk     (clk),
		.reset   (reset),
		.i_write (i_write),
		.i_data  (i_data),
		.i_pop   (tx_pop),
		.o_head  (fifo_head),
		.o_empty (fifo_empty),
		.o_full  (o_full)
	);

	uart_tx uart_tx_i (
		.clk      (clk),
		.reset    (reset),
		.i_head   (fifo_head),
		.i_empty  (fifo_empty),
		.o_pop    (tx_pop),
		.o_serial (o_serial),
		.o_busy   (o_busy)
	);

	// receive side sees whatever drives i_serial, loop is closed outside
	uart_rx uart_rx_i (
		.clk          (clk),
		.reset        (reset),
		.i_serial     (i_serial),
		.o_data       (o_data),
		.o_data_valid (o_data_valid),
		.o_rx_error   (o_rx_error)
	);

endmodule

//--- sim/uart_loop_assert.sv
module uart_loop_assert (
	input logic clk,
	input logic reset,
	input logic i_line,       // transmitter line out
	input logic i_busy,
	input logic i_full,
	input logic i_data_valid  // receiver strobe
);
	timeunit 1ns;
	timeprecision 100ps;

	// nothing queued and nothing sending, so the line must idle high
	idle_line_high: assert property (
		@(posedge clk) disable iff (reset)
		!i_busy |-> i_line
	) else $error("o_serial low while o_busy is low");

	// receiver strobe is a single-cycle pulse
	valid_one_cycle: assert property (
		@(posedge clk) disable iff (reset)
		i_data_valid |=> !i_data_valid
	) else $error("o_data_valid high for two cycles in a row");

	// a full fifo holds words, which counts as busy
	full_means_busy: assert property (
		@(posedge clk) disable iff (reset)
		i_full |-> i_busy
	) else $error("o_full high while o_busy is low");

endmodule

bind uart_loop uart_loop_assert uart_loop_assert_i (
	.clk          (clk),
	.reset        (reset),
	.i_line       (o_serial),
	.i_busy       (o_busy),
	.i_full       (o_full),
	.i_data_valid (o_data_valid)
);

//--- sim/uart_loop_tb.sv
`include "uart_cfg.svh"

module uart_loop_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import uart_pkg::*;

	localparam int N_SINGLE = 100; // looped bytes, one at a time
	localparam int N_BURSTS = 20;  // back-pressure bursts
	localparam int N_INJECT = 10;  // corrupt frames of each kind
	localparam int N_GLITCH = 4;   // false starts, each followed by a good frame
	localparam int GLITCH_CYCLES = `UART_CLKS_PER_BIT / 2 - 2; // well short of half a bit
	// budget of 300 frames, each allowed twice its length on the line
	localparam int TIMEOUT_CYCLES = 300 * FRAME_BITS * `UART_CLKS_PER_BIT * 2;

	typedef struct packed {
		uart_data_t data; // word the receiver must report
		logic       err;  // expected o_rx_error
	} exp_t;

	logic       clk;
	logic       reset;
	logic       i_write;
	uart_data_t i_data;
	logic       line_in;     // what the receiver sees
	logic       o_full;
	logic       o_busy;
	logic       o_serial;
	uart_data_t o_data;
	logic       o_data_valid;
	logic       o_rx_error;
	logic       use_bitbang; // 0 loops o_serial back, 1 hands the line to the tb
	logic       bb_line;     // bit-banged line level
	integer     seed = 32'h5c94;
	exp_t       exp_q[$];    // reference model, oldest first
	int         cycle_cnt = 0;
	int         dropped = 0; // writes refused while full

	assign line_in = use_bitbang ? bb_line : o_serial;

	uart_loop uart_loop_i (
		.clk          (clk),
		.reset        (reset),
		.i_write      (i_write),
		.i_data       (i_data),
		.i_serial     (line_in),
		.o_full       (o_full),
		.o_busy       (o_busy),
		.o_serial     (o_serial),
		.o_data       (o_data),
		.o_data_valid (o_data_valid),
		.o_rx_error   (o_rx_error)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	task automatic fail_run(input string why);
		$display("error: %s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_data(input string name, input uart_data_t got, input uart_data_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run("data word differs from the reference model");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run("flag differs from the reference model");
		end
	endtask

	function automatic int rand_below(input int bound);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % bound;
	endfunction

	// parity bit as the line should carry it
	function automatic logic frame_parity(input uart_data_t d);
		logic p;
		p = 1'(`UART_PARITY_ODD);
		for (int i = 0; i < `UART_DATA_WIDTH; i++) begin
			p = p ^ d[i];
		end
		return p;
	endfunction

	// called on a falling edge, returns one falling edge later
	task automatic drive_write(input uart_data_t d);
		i_write = 1'b1;
		i_data  = d;
		if (!o_full) begin
			exp_q.push_back('{data: d, err: 1'b0}); // accepted at the next rising edge
		end else begin
			dropped++; // the fifo ignores it
		end
		@(negedge clk);
		i_write = 1'b0;
	endtask

	task automatic send_frame(input uart_data_t d, input logic bad_parity, input logic bad_stop);
		logic [FRAME_BITS-1:0] bits;
		bits = {~bad_stop, frame_parity(d) ^ bad_parity, d, 1'b0}; // stop, parity, data, start
		exp_q.push_back('{data: d, err: bad_parity || bad_stop});
		for (int i = 0; i < FRAME_BITS; i++) begin
			bb_line = bits[i]; // lsb first
			repeat (`UART_CLKS_PER_BIT) @(negedge clk);
		end
		bb_line = 1'b1;
		repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk); // idle gap
	endtask

	// short low pulse, then enough quiet time for a wrongly accepted frame to show up
	task automatic send_glitch();
		bb_line = 1'b0;
		repeat (GLITCH_CYCLES) @(negedge clk);
		bb_line = 1'b1;
		repeat ((FRAME_BITS + 2) * `UART_CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic wait_drained();
		while (o_busy || exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
	endtask

	// receiver monitor, outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset && o_data_valid) begin
			if (exp_q.size() == 0) begin
				fail_run("received data with nothing outstanding");
			end else begin
				check_data("o_data", o_data, exp_q[0].data);
				check_flag("o_rx_error", o_rx_error, exp_q[0].err);
				void'(exp_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			fail_run("timeout, the test did not finish within its cycle limit");
		end
	end

	initial begin
		int len;
		reset       = 1'b1;
		i_write     = 1'b0;
		i_data      = '0;
		use_bitbang = 1'b0;
		bb_line     = 1'b1;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		check_flag("o_serial", o_serial, 1'b1); // idle values out of reset
		check_flag("o_busy", o_busy, 1'b0);
		check_flag("o_full", o_full, 1'b0);
		check_flag("o_data_valid", o_data_valid, 1'b0);
		check_flag("o_rx_error", o_rx_error, 1'b0);

		for (int n = 0; n < N_SINGLE; n++) begin
			while (o_busy) begin
				@(negedge clk);
			end
			drive_write(uart_data_t'($random(seed)));
		end
		wait_drained();

		for (int n = 0; n < N_BURSTS; n++) begin
			len = 2 + rand_below(7); // up to 8, twice the fifo depth
			for (int k = 0; k < len; k++) begin
				drive_write(uart_data_t'($random(seed)));
			end
			repeat (rand_below(40)) @(negedge clk);
		end
		wait_drained();

		use_bitbang = 1'b1; // tx is idle, line stays high across the switch
		repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
		for (int n = 0; n < N_INJECT; n++) begin
			send_frame(uart_data_t'($random(seed)), 1'b1, 1'b0); // flipped parity
		end
		for (int n = 0; n < N_INJECT; n++) begin
			send_frame(uart_data_t'($random(seed)), 1'b0, 1'b1); // low stop bit
		end
		for (int n = 0; n < N_GLITCH; n++) begin
			send_glitch();
			send_frame(uart_data_t'($random(seed)), 1'b0, 1'b0);
		end
		wait_drained();
		use_bitbang = 1'b0;

		if (dropped == 0) begin
			$display("error: no write was refused, the full FIFO was never reached");
			$display("*** TEST FAILED ***");
			$fatal(1, "back-pressure not exercised");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- src.f
+incdir+logic
logic/uart_pkg.sv
logic/tx_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_loop.sv
sim/uart_loop_assert.sv
sim/uart_loop_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the loop testbench with Verilator and run it
# exit status is nonzero when the build fails or the testbench stops on $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	-f src.f \
	--top-module uart_loop_tb \
	-Mdir obj_dir &&
./obj_dir/Vuart_loop_tb ||
{ echo "simulation failed"; exit 1; }
